//--- filelist.f
source/map_bus_pkg.sv
source/map_cfg_pkg.sv
source/mmc6_bank_regs.sv
source/mmc6_addr_map.sv
source/mmc3_irq_counter.sv
source/mmc6_mapper.sv
tests/mmc6_mapper_assertions.sv
tests/mmc6_mapper_tb.sv

//--- tests/mmc6_mapper_tb.sv
module mmc6_mapper_tb
	import map_bus_pkg::*, map_cfg_pkg::*;
();

	logic              m2, map_rst, cpu_rw, ppu_oe, ppu_we;
	logic              ss_act, ss_we, cfg_mir_v, cfg_chr_ram;
	logic [CPU_AW-1:0] cpu_addr;
	logic [CPU_DW-1:0] cpu_dat;
	logic [PPU_AW-1:0] ppu_addr;
	logic [7:0]        ss_addr;
	logic [PRG_AW-1:0] prg_addr;
	logic [CHR_AW-1:0] chr_addr;
	logic [SRM_AW-1:0] srm_addr;
	logic              prg_oe, chr_oe, rom_ce, ram_ce, ram_we, chr_ce, chr_we;
	logic              ciram_a10, ciram_ce, irq;
	logic [CPU_DW-1:0] ss_rdat;

	// Reference model of the mapper registers
	logic [7:0] mdl_bank [8];
	bank_sel_u  mdl_sel;
	logic [7:0] mdl_ctrl0, mdl_ctrl1, mdl_latch, mdl_cnt;
	logic       mdl_reload, mdl_en, mdl_irq;
	int         mdl_low;	// Consecutive A12 low samples

	integer      seed;
	int          err_cnt, chk_cnt, rises;
	logic        chk_en, rst_req, chr_ram_sel, irq_smp;
	logic [31:0] r;
	logic [7:0]  lat, sad;

	mmc6_mapper i_mmc6_mapper (.*);

	always #4 m2 = ~m2;

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	function automatic logic [PRG_AW-1:0] prg_map(input logic [CPU_AW-1:0] a);
		logic [7:0] b;
		case (a[14:13])
			2'd0:    b = mdl_sel.f.prg_mode ? 8'h3E : mdl_bank[6];
			2'd1:    b = mdl_bank[7];
			2'd2:    b = mdl_sel.f.prg_mode ? mdl_bank[6] : 8'h3E;
			default: b = 8'h3F;
		endcase
		return {b[5:0], a[12:0]};
	endfunction

	function automatic logic [CHR_AW-1:0] chr_map(input logic [PPU_AW-1:0] p, input logic ram);
		logic [2:0] k;
		logic [7:0] b;
		k = p[12:10] ^ {mdl_sel.f.chr_mode, 2'b00};	// Slots 0..3 hold the 2K pair
		b = k[2] ? mdl_bank[2 + k[1:0]] : {(k[1] ? mdl_bank[1][7:1] : mdl_bank[0][7:1]), k[0]};
		b[7:5] = ram ? 3'b000 : b[7:5];	// 32 KB of CHR RAM
		return {b, p[9:0]};
	endfunction

	function automatic logic [7:0] ss_read_model(input logic [7:0] a);
		case (a)
			8'd8:    return mdl_sel.raw;
			8'd9:    return mdl_ctrl0;
			8'd10:   return mdl_ctrl1;
			8'd16:   return mdl_latch;
			8'd17:   return mdl_cnt;
			8'd18:   return {7'd0, mdl_reload};
			8'd19:   return {7'd0, mdl_en};
			8'd20:   return {7'd0, mdl_irq};
			8'd127:  return 8'd4;
			default: return (a < 8) ? mdl_bank[a[2:0]] : 8'hFF;
		endcase
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		chk_cnt++;
		assert (got === exp) else
		begin
			err_cnt++;
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_outputs();
		logic rce;
		rce = (cpu_addr[15:12] == 4'h7) && mdl_sel.f.ram_en;
		check_eq("prg_addr", prg_addr, prg_map(cpu_addr));
		check_eq("chr_addr", chr_addr, chr_map(ppu_addr, cfg_chr_ram));
		check_eq("srm_addr", srm_addr, cpu_addr[9:0]);
		check_eq("ram_ce", ram_ce, rce);
		check_eq("ram_we", ram_we, rce && !cpu_rw);
		check_eq("ciram_a10", ciram_a10, mdl_ctrl0[0] ? ppu_addr[11] : ppu_addr[10]);
		check_eq("prg_oe", prg_oe, cpu_rw);
		check_eq("chr_oe", chr_oe, !ppu_oe);
		check_eq("chr_ce", chr_ce, !ppu_addr[13]);
		check_eq("chr_we", chr_we, cfg_chr_ram && !ppu_we);
		check_eq("irq", irq, mdl_irq);
		check_eq("ss_rdat", ss_rdat, ss_read_model(ss_addr));
	endtask

	// Applied at each falling edge of m2
	task automatic update_model();
		logic rise;
		rise = ppu_addr[12] && (mdl_low >= A12_FILTER);
		if (map_rst)
		begin
			foreach (mdl_bank[i])
			begin
				mdl_bank[i] = BANK_RESET[i];
			end
			mdl_sel = '0;
			mdl_ctrl0 = {7'd0, ~cfg_mir_v};
			mdl_ctrl1 = 8'd0;
			mdl_latch = 8'd0;
			mdl_cnt = 8'd0;
			mdl_reload = 1'b0;
			mdl_en = 1'b0;
			mdl_irq = 1'b0;
			mdl_low = 0;
		end
		else if (ss_act)
		begin
			if (ss_we)
			begin
				case (ss_addr)
					8'd8:    mdl_sel.raw = cpu_dat;
					8'd9:    mdl_ctrl0 = cpu_dat;
					8'd10:   mdl_ctrl1 = cpu_dat;
					default: mdl_bank[ss_addr[2:0]] = (ss_addr < 8) ? cpu_dat : mdl_bank[ss_addr[2:0]];
				endcase
			end
		end
		else
		begin
			mdl_low = ppu_addr[12] ? 0 : ((mdl_low < A12_FILTER) ? mdl_low + 1 : mdl_low);
			if (rise)
			begin
				mdl_cnt = (mdl_cnt == 0 || mdl_reload) ? mdl_latch : mdl_cnt - 8'd1;
				mdl_reload = 1'b0;
				mdl_irq = mdl_irq | (mdl_cnt == 0 && mdl_en);
			end
			if (!cpu_rw)
			begin
				case (cpu_addr & 16'hE001)	// Register decode on A15..A13 and A0
					16'h8000: mdl_sel.raw = cpu_dat;
					16'h8001: mdl_bank[mdl_sel.f.reg_idx] = cpu_dat;
					16'hA000: mdl_ctrl0 = cpu_dat;
					16'hA001: mdl_ctrl1 = cpu_dat;
					16'hC000: mdl_latch = cpu_dat;
					16'hC001: mdl_reload = 1'b1;
					16'hE000:
					begin
						mdl_en = 1'b0;
						mdl_irq = 1'b0;
					end
					16'hE001: mdl_en = 1'b1;
					default:  mdl_en = mdl_en;
				endcase
			end
		end
	endtask

	task automatic bus_cycle(input logic [CPU_AW-1:0] a, input logic [7:0] d, input logic rw,
		input logic [PPU_AW-1:0] p, input logic sa, input logic swe, input logic [7:0] sad_in);
		logic [31:0] v;
		v = next_rand();
		@(posedge m2);
		map_rst <= rst_req;
		cpu_addr <= a;
		cpu_dat <= d;
		cpu_rw <= rw;
		ppu_addr <= p;
		ppu_oe <= v[0];
		ppu_we <= v[1];
		ss_act <= sa;
		ss_we <= swe;
		ss_addr <= sad_in;
		cfg_chr_ram <= chr_ram_sel;
		#2;	// Outputs settled before the falling edge
		if (chk_en)
		begin
			check_outputs();
		end
		irq_smp = irq;
		@(negedge m2);
		update_model();
	endtask

	// Random CPU reads where a12 of 0 or 1 forces PPU A12
	task automatic read_cycles(input int n, input int a12);
		logic [31:0] v;
		repeat (n)
		begin
			v = next_rand();
			v[12] = (a12 < 2) ? a12[0] : v[12];
			bus_cycle(next_rand(), v[21:14], 1'b1, v[13:0], 1'b0, 1'b0, v[29:22]);
		end
	endtask

	initial
	begin
		seed = 32'h237b_8965;
		err_cnt = 0;
		chk_cnt = 0;
		m2 = 1'b0;
		map_rst = 1'b1;
		cpu_addr = '0;
		cpu_dat = '0;
		cpu_rw = 1'b1;
		ppu_addr = '0;
		ppu_oe = 1'b1;
		ppu_we = 1'b1;
		ss_act = 1'b0;
		ss_we = 1'b0;
		ss_addr = '0;
		cfg_chr_ram = 1'b0;
		r = next_rand();
		cfg_mir_v = r[0];
		chk_en = 1'b0;
		rst_req = 1'b1;
		chr_ram_sel = 1'b0;
		irq_smp = 1'b0;
		read_cycles(8, 2);
		rst_req = 1'b0;
		chk_en = 1'b1;
		read_cycles(24, 2);	// Reset mapping

		repeat (40)
		begin
			r = next_rand();
			chr_ram_sel = r[31];
			bus_cycle({3'b100, r[12:1], 1'b0}, r[20:13], 1'b0, next_rand(), 1'b0, 1'b0, r[28:21]);
			r = next_rand();
			bus_cycle({3'b100, r[12:1], 1'b1}, r[20:13], 1'b0, next_rand(), 1'b0, 1'b0, r[28:21]);
			read_cycles(4, 2);
		end
		chr_ram_sel = 1'b0;

		repeat (30)
		begin
			r = next_rand();
			bus_cycle({3'b101, r[12:1], 1'b0}, r[20:13], 1'b0, next_rand(), 1'b0, 1'b0, r[28:21]);
			r = next_rand();
			bus_cycle(16'h8000, r[7:0] | 8'h20, 1'b0, next_rand(), 1'b0, 1'b0, r[15:8]);
			repeat (3)
			begin
				r = next_rand();
				bus_cycle({4'h7, r[11:0]}, r[19:12], r[20], next_rand(), 1'b0, 1'b0, r[28:21]);
			end
		end

		repeat (4)
		begin
			r = next_rand();
			lat = {4'd0, r[3:0]};
			bus_cycle(16'hE000, r[15:8], 1'b0, '0, 1'b0, 1'b0, 8'd0);
			bus_cycle(16'hC000, lat, 1'b0, '0, 1'b0, 1'b0, 8'd0);
			bus_cycle(16'hC001, r[23:16], 1'b0, '0, 1'b0, 1'b0, 8'd0);
			bus_cycle(16'hE001, r[31:24], 1'b0, '0, 1'b0, 1'b0, 8'd0);
			read_cycles(3, 0);
			rises = 0;
			irq_smp = 1'b0;
			while (!irq_smp && rises < 40)
			begin
				read_cycles(1, 1);	// Counted rise
				rises++;
				read_cycles(1, 0);
				read_cycles(1, 1);	// Short low stretch that must not count
				read_cycles(3, 0);
			end
			assert (irq_smp) else
			begin
				err_cnt++;
				$display("IRQ did not rise within 40 filtered A12 rises");
			end
			check_eq("irq rise count", rises, lat + 1);
			bus_cycle(16'hE000, r[15:8], 1'b0, '0, 1'b0, 1'b0, 8'd0);
			read_cycles(1, 0);
			check_eq("irq after E000h", irq_smp, 0);
		end

		// State writes with a blocked CPU write on the same cycle
		repeat (40)
		begin
			r = next_rand();
			sad = {4'd0, r[26:23] % 4'd11};
			bus_cycle({1'b1, r[14], 1'b0, 12'd0, r[13]}, r[22:15], 1'b0, next_rand(), 1'b1, 1'b1,
				sad);
		end
		repeat (40)
		begin
			r = next_rand();
			sad = r[1] ? (r[0] ? 8'd127 : r[31:24]) : {4'd0, r[5:2] % 4'd11};
			bus_cycle({1'b1, r[14], 1'b0, 12'd0, r[13]}, r[22:15], 1'b0, next_rand(), 1'b1, 1'b0,
				sad);
		end
		read_cycles(10, 2);

		$display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- tests/mmc6_mapper_assertions.sv
module mmc6_mapper_assertions
	import map_bus_pkg::*;
(
	input logic              m2,
	input logic              map_rst,
	input logic [CPU_AW-1:0] cpu_addr,
	input logic [PPU_AW-1:0] ppu_addr,
	input logic              irq,
	input logic              rom_ce,
	input logic              ram_ce,
	input logic              ram_we,
	input logic              ciram_ce
);

	irq_after_reset: assert property (@(negedge m2) map_rst |=> !irq)
		else $error("irq high on the edge after reset");

	ram_we_in_window: assert property (@(posedge m2) disable iff (map_rst)
		ram_we |-> ram_ce)
		else $error("ram_we asserted without ram_ce");

	// Nametable RAM only at 2000h and above
	ciram_on_a13: assert property (@(posedge m2) disable iff (map_rst)
		ciram_ce == !ppu_addr[13])
		else $error("ciram_ce does not follow inverted PPU A13");

	rom_on_a15: assert property (@(posedge m2) disable iff (map_rst)
		rom_ce == cpu_addr[15])
		else $error("rom_ce does not follow CPU A15");

endmodule

bind mmc6_mapper mmc6_mapper_assertions i_assertions (.*);

//--- source/mmc6_mapper.sv
module mmc6_mapper
	import map_bus_pkg::*, map_cfg_pkg::*;
(
	input  logic              m2,
	input  logic              map_rst,
	input  logic [CPU_AW-1:0] cpu_addr,
	input  logic [CPU_DW-1:0] cpu_dat,
	input  logic              cpu_rw,
	input  logic [PPU_AW-1:0] ppu_addr,
	input  logic              ppu_oe,
	input  logic              ppu_we,
	input  logic              ss_act,
	input  logic              ss_we,
	input  logic [7:0]        ss_addr,
	input  logic              cfg_mir_v,
	input  logic              cfg_chr_ram,
	output logic [PRG_AW-1:0] prg_addr,
	output logic [CHR_AW-1:0] chr_addr,
	output logic [SRM_AW-1:0] srm_addr,
	output logic              prg_oe,
	output logic              chr_oe,
	output logic              rom_ce,
	output logic              ram_ce,
	output logic              ram_we,
	output logic              chr_ce,
	output logic              chr_we,
	output logic              ciram_a10,
	output logic              ciram_ce,
	output logic              irq,
	output logic [CPU_DW-1:0] ss_rdat
);

	logic [7:0][CPU_DW-1:0] bank_dat;
	bank_sel_u              bank_sel;
	logic                   mir_mod;
	logic [CPU_DW-1:0]      bank_ss_rdat;
	logic [CPU_DW-1:0]      irq_ss_rdat;

	mmc6_bank_regs i_bank_regs (
		.m2           (m2),
		.map_rst      (map_rst),
		.cpu_addr     (cpu_addr),
		.cpu_dat      (cpu_dat),
		.cpu_rw       (cpu_rw),
		.ss_act       (ss_act),
		.ss_we        (ss_we),
		.ss_addr      (ss_addr),
		.cfg_mir_v    (cfg_mir_v),
		.bank_dat     (bank_dat),
		.bank_sel     (bank_sel),
		.mir_mod      (mir_mod),
		.bank_ss_rdat (bank_ss_rdat)
	);

	mmc6_addr_map i_addr_map (
		.cpu_addr    (cpu_addr),
		.cpu_rw      (cpu_rw),
		.ppu_addr    (ppu_addr),
		.ppu_oe      (ppu_oe),
		.ppu_we      (ppu_we),
		.cfg_chr_ram (cfg_chr_ram),
		.bank_dat    (bank_dat),
		.bank_sel    (bank_sel),
		.mir_mod     (mir_mod),
		.prg_addr    (prg_addr),
		.chr_addr    (chr_addr),
		.srm_addr    (srm_addr),
		.prg_oe      (prg_oe),
		.chr_oe      (chr_oe),
		.rom_ce      (rom_ce),
		.ram_ce      (ram_ce),
		.ram_we      (ram_we),
		.chr_ce      (chr_ce),
		.chr_we      (chr_we),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce)
	);

	mmc3_irq_counter i_irq_counter (
		.m2          (m2),
		.map_rst     (map_rst),
		.cpu_addr    (cpu_addr),
		.cpu_dat     (cpu_dat),
		.cpu_rw      (cpu_rw),
		.ppu_addr    (ppu_addr),
		.ss_act      (ss_act),
		.ss_we       (ss_we),
		.ss_addr     (ss_addr),
		.irq         (irq),
		.irq_ss_rdat (irq_ss_rdat)
	);

	// Save-state read mux by address range
	always_comb
	begin
		if (ss_addr <= SS_MMC_CTRL1)
		begin
			ss_rdat = bank_ss_rdat;	// 0..10
		end
		else if (ss_addr[7:3] == SS_IRQ_BASE[7:3])
		begin
			ss_rdat = irq_ss_rdat;	// 16..23
		end
		else if (ss_addr == SS_MAP_IDX)
		begin
			ss_rdat = MAP_IDX;
		end
		else
		begin
			ss_rdat = 8'hFF;
		end
	end

endmodule

//--- source/mmc3_irq_counter.sv
module mmc3_irq_counter
	import map_bus_pkg::*, map_cfg_pkg::*;
(
	input  logic              m2,
	input  logic              map_rst,
	input  logic [CPU_AW-1:0] cpu_addr,
	input  logic [CPU_DW-1:0] cpu_dat,
	input  logic              cpu_rw,
	input  logic [PPU_AW-1:0] ppu_addr,
	input  logic              ss_act,
	input  logic              ss_we,
	input  logic [7:0]        ss_addr,
	output logic              irq,
	output logic [CPU_DW-1:0] irq_ss_rdat
);

	localparam int FILT_W = $clog2(A12_FILTER + 1);

	logic [CPU_DW-1:0] irq_latch;
	logic [CPU_DW-1:0] irq_cnt;
	logic [CPU_DW-1:0] cnt_next;
	logic              irq_reload;	// Load latch on next counted rise
	logic              irq_en;
	logic [FILT_W-1:0] a12_low;	// Consecutive low samples, saturating
	logic              a12_rise;
	logic [CPU_AW-1:0] reg_addr;
	logic              ss_hit;

	assign reg_addr = {cpu_addr[15:13], 12'd0, cpu_addr[0]};
	assign ss_hit = ss_addr[7:3] == SS_IRQ_BASE[7:3];

	// A12 high after a long enough low stretch is one scanline
	assign a12_rise = ppu_addr[12] && (a12_low == FILT_W'(A12_FILTER));
	assign cnt_next = (irq_cnt == '0 || irq_reload) ? irq_latch : irq_cnt - 1'b1;

	always_ff @(negedge m2)
	begin
		if (map_rst)
		begin
			irq_latch <= '0;
			irq_cnt <= '0;
			irq_reload <= 1'b0;
			irq_en <= 1'b0;
			irq <= 1'b0;
			a12_low <= '0;
		end
		else if (ss_act)
		begin
			// Counter frozen while the state is saved or restored
			if (ss_we && ss_hit)
			begin
				case (ss_addr[2:0])
					3'd0:    irq_latch <= cpu_dat;
					3'd1:    irq_cnt <= cpu_dat;
					3'd2:    irq_reload <= cpu_dat[0];
					3'd3:    irq_en <= cpu_dat[0];
					3'd4:    irq <= cpu_dat[0];
					default: irq_latch <= irq_latch;
				endcase
			end
		end
		else
		begin
			if (ppu_addr[12])
			begin
				a12_low <= '0;
			end
			else if (a12_low != FILT_W'(A12_FILTER))
			begin
				a12_low <= a12_low + 1'b1;
			end

			if (a12_rise)
			begin
				irq_cnt <= cnt_next;
				irq_reload <= 1'b0;
				if (cnt_next == '0 && irq_en)
				begin
					irq <= 1'b1;
				end
			end

			// CPU writes come last and win over a rise on the same edge
			if (!cpu_rw)
			begin
				case (reg_addr)
					REG_IRQ_LATCH:  irq_latch <= cpu_dat;
					REG_IRQ_RELOAD: irq_reload <= 1'b1;
					REG_IRQ_OFF:
					begin
						irq_en <= 1'b0;
						irq <= 1'b0;	// Acknowledge
					end
					REG_IRQ_ON:     irq_en <= 1'b1;
					default:        irq_en <= irq_en;
				endcase
			end
		end
	end

	always_comb
	begin
		case (ss_addr[2:0])
			3'd0:    irq_ss_rdat = irq_latch;
			3'd1:    irq_ss_rdat = irq_cnt;
			3'd2:    irq_ss_rdat = {{(CPU_DW - 1){1'b0}}, irq_reload};
			3'd3:    irq_ss_rdat = {{(CPU_DW - 1){1'b0}}, irq_en};
			3'd4:    irq_ss_rdat = {{(CPU_DW - 1){1'b0}}, irq};
			default: irq_ss_rdat = 8'hFF;
		endcase
	end

endmodule

//--- source/mmc6_addr_map.sv
module mmc6_addr_map
	import map_bus_pkg::*, map_cfg_pkg::*;
(
	input  logic [CPU_AW-1:0]      cpu_addr,
	input  logic                   cpu_rw,
	input  logic [PPU_AW-1:0]      ppu_addr,
	input  logic                   ppu_oe,
	input  logic                   ppu_we,
	input  logic                   cfg_chr_ram,
	input  logic [7:0][CPU_DW-1:0] bank_dat,
	input  bank_sel_u              bank_sel,
	input  logic                   mir_mod,
	output logic [PRG_AW-1:0]      prg_addr,
	output logic [CHR_AW-1:0]      chr_addr,
	output logic [SRM_AW-1:0]      srm_addr,
	output logic                   prg_oe,
	output logic                   chr_oe,
	output logic                   rom_ce,
	output logic                   ram_ce,
	output logic                   ram_we,
	output logic                   chr_ce,
	output logic                   chr_we,
	output logic                   ciram_a10,
	output logic                   ciram_ce
);

	logic [5:0] prg_bank;	// 8 KB bank for the current CPU slot
	logic [7:0] chr_bank;	// 1 KB bank for the current PPU slot
	logic [7:0] chr_trim;

	// PRG windows of 8 KB at 8000h, A000h, C000h and E000h
	always_comb
	begin
		case (cpu_addr[14:13])
			2'd0:    prg_bank = bank_sel.f.prg_mode ? 6'h3E : bank_dat[6][5:0];
			2'd1:    prg_bank = bank_dat[7][5:0];
			2'd2:    prg_bank = bank_sel.f.prg_mode ? bank_dat[6][5:0] : 6'h3E;
			default: prg_bank = 6'h3F;	// Last bank always at E000h
		endcase
	end

	assign prg_addr = {prg_bank, cpu_addr[12:0]};

	// CHR has two 2 KB banks in one half and four 1 KB banks in the other
	always_comb
	begin
		if (ppu_addr[12:11] == {bank_sel.f.chr_mode, 1'b0})
		begin
			chr_bank = {bank_dat[0][7:1], ppu_addr[10]};
		end
		else if (ppu_addr[12:11] == {bank_sel.f.chr_mode, 1'b1})
		begin
			chr_bank = {bank_dat[1][7:1], ppu_addr[10]};
		end
		else
		begin
			case (ppu_addr[11:10])
				2'd0:    chr_bank = bank_dat[2];
				2'd1:    chr_bank = bank_dat[3];
				2'd2:    chr_bank = bank_dat[4];
				default: chr_bank = bank_dat[5];
			endcase
		end
	end

	// CHR RAM carts carry at most 32 KB
	assign chr_trim = cfg_chr_ram ? {3'd0, chr_bank[4:0]} : chr_bank;
	assign chr_addr = {chr_trim, ppu_addr[9:0]};

	assign prg_oe = cpu_rw;
	assign chr_oe = ~ppu_oe;
	assign rom_ce = cpu_addr[15];

	// MMC6 RAM is mirrored across 7000h..7FFFh
	assign srm_addr = cpu_addr[SRM_AW-1:0];
	assign ram_ce = ({cpu_addr[15:12], 12'd0} == SRAM_WINDOW) && bank_sel.f.ram_en;
	assign ram_we = ~cpu_rw & ram_ce;	// No per-half protect

	assign ciram_ce = ~ppu_addr[13];
	assign chr_ce = ciram_ce;
	assign chr_we = cfg_chr_ram & ~ppu_we;

	// Vertical mirroring on A10, horizontal on A11
	assign ciram_a10 = mir_mod ? ppu_addr[11] : ppu_addr[10];

endmodule

//--- source/mmc6_bank_regs.sv
module mmc6_bank_regs
	import map_bus_pkg::*, map_cfg_pkg::*;
(
	input  logic                   m2,
	input  logic                   map_rst,
	input  logic [CPU_AW-1:0]      cpu_addr,
	input  logic [CPU_DW-1:0]      cpu_dat,
	input  logic                   cpu_rw,
	input  logic                   ss_act,
	input  logic                   ss_we,
	input  logic [7:0]             ss_addr,
	input  logic                   cfg_mir_v,
	output logic [7:0][CPU_DW-1:0] bank_dat,
	output bank_sel_u              bank_sel,
	output logic                   mir_mod,
	output logic [CPU_DW-1:0]      bank_ss_rdat
);

	logic [CPU_DW-1:0] mmc_ctrl0;	// Bit 0 selects horizontal mirroring
	logic [CPU_DW-1:0] mmc_ctrl1;	// RAM control, kept for the save state
	logic [CPU_AW-1:0] reg_addr;
	logic              ss_bank_hit;

	// Only A15..A13 and A0 take part in the register decode
	assign reg_addr = {cpu_addr[15:13], 12'd0, cpu_addr[0]};

	assign ss_bank_hit = ss_addr[7:3] == SS_BANK_BASE[7:3];
	assign mir_mod = mmc_ctrl0[0];

	always_ff @(negedge m2)
	begin
		if (map_rst)
		begin
			bank_dat <= BANK_RESET;
			bank_sel <= '0;
			mmc_ctrl0 <= {{(CPU_DW - 1){1'b0}}, ~cfg_mir_v};	// Header mirroring inverted
			mmc_ctrl1 <= '0;
		end
		else if (ss_act)
		begin
			// Save-state access owns the registers, CPU writes are dropped
			if (ss_we)
			begin
				if (ss_bank_hit)
				begin
					bank_dat[ss_addr[2:0]] <= cpu_dat;
				end
				if (ss_addr == SS_BANK_SEL)
				begin
					bank_sel.raw <= cpu_dat;
				end
				if (ss_addr == SS_MMC_CTRL0)
				begin
					mmc_ctrl0 <= cpu_dat;
				end
				if (ss_addr == SS_MMC_CTRL1)
				begin
					mmc_ctrl1 <= cpu_dat;
				end
			end
		end
		else if (!cpu_rw)
		begin
			case (reg_addr)
				REG_BANK_SEL:
				begin
					bank_sel.raw <= cpu_dat;
				end
				REG_BANK_DAT:
				begin
					bank_dat[bank_sel.f.reg_idx] <= cpu_dat;	// Register picked by 8000h
				end
				REG_MIRROR:
				begin
					mmc_ctrl0 <= cpu_dat;
				end
				REG_RAM_CTRL:
				begin
					mmc_ctrl1 <= cpu_dat;
				end
				default:
				begin
				end
			endcase
		end
	end

	// Readback for save-state addresses 0..10
	always_comb
	begin
		bank_ss_rdat = 8'hFF;
		if (!ss_addr[3])
		begin
			bank_ss_rdat = bank_dat[ss_addr[2:0]];
		end
		else
		begin
			case (ss_addr[3:0])
				SS_BANK_SEL[3:0]:  bank_ss_rdat = bank_sel.raw;
				SS_MMC_CTRL0[3:0]: bank_ss_rdat = mmc_ctrl0;
				SS_MMC_CTRL1[3:0]: bank_ss_rdat = mmc_ctrl1;
				default:           bank_ss_rdat = 8'hFF;
			endcase
		end
	end

endmodule

//--- source/map_cfg_pkg.sv
package map_cfg_pkg;

	// Power-on bank numbers for registers 0..7, index 0 in the low byte
	localparam logic [7:0][7:0] BANK_RESET = {
		8'd1,	// R7 PRG
		8'd0,	// R6 PRG
		8'd7,	// R5 CHR 1K
		8'd6,	// R4 CHR 1K
		8'd5,	// R3 CHR 1K
		8'd4,	// R2 CHR 1K
		8'd2,	// R1 CHR 2K
		8'd0	// R0 CHR 2K
	};

	// Save-state address map
	localparam logic [7:0] SS_BANK_BASE = 8'd0;	// Bank data 0..7
	localparam logic [7:0] SS_BANK_SEL  = 8'd8;
	localparam logic [7:0] SS_MMC_CTRL0 = 8'd9;	// Mirroring byte
	localparam logic [7:0] SS_MMC_CTRL1 = 8'd10;	// RAM control byte
	localparam logic [7:0] SS_IRQ_BASE  = 8'd16;	// IRQ block 16..23
	localparam logic [7:0] SS_MAP_IDX   = 8'd127;

	// Mapper number reported through the save state
	localparam logic [7:0] MAP_IDX = 8'd4;

	// Low samples of PPU A12 needed before a rise clocks the counter
	localparam int A12_FILTER = 3;

	// Bank-select byte, written as a whole and decoded as fields
	typedef union packed {
		logic [7:0] raw;	// CPU and save-state view
		struct packed {
			logic       chr_mode;	// Swap 2K and 1K CHR halves
			logic       prg_mode;	// Swap 8000h and C000h PRG slots
			logic       ram_en;	// MMC6 RAM enable
			logic [1:0] unused;
			logic [2:0] reg_idx;	// Target of the next 8001h write
		} f;
	} bank_sel_u;

endpackage

//--- source/map_bus_pkg.sv
package map_bus_pkg;

	// CPU side of the cartridge edge
	localparam int CPU_AW = 16;	// A15..A0
	localparam int CPU_DW = 8;	// D7..D0

	// PPU side, 16 KB address space
	localparam int PPU_AW = 14;

	// ROM and RAM address widths driven out to the memory controller
	localparam int PRG_AW = 19;	// 512 KB PRG ROM
	localparam int CHR_AW = 18;	// 256 KB CHR ROM
	localparam int SRM_AW = 10;	// 1 KB MMC6 internal RAM

	// Register map, valid after masking the CPU address to A15..A13 and A0
	localparam logic [CPU_AW-1:0] REG_BANK_SEL   = 16'h8000;	// Bank select
	localparam logic [CPU_AW-1:0] REG_BANK_DAT   = 16'h8001;	// Bank data
	localparam logic [CPU_AW-1:0] REG_MIRROR     = 16'hA000;	// Mirroring
	localparam logic [CPU_AW-1:0] REG_RAM_CTRL   = 16'hA001;	// RAM control
	localparam logic [CPU_AW-1:0] REG_IRQ_LATCH  = 16'hC000;	// Counter reload value
	localparam logic [CPU_AW-1:0] REG_IRQ_RELOAD = 16'hC001;	// Arm reload
	localparam logic [CPU_AW-1:0] REG_IRQ_OFF    = 16'hE000;	// Disable and acknowledge
	localparam logic [CPU_AW-1:0] REG_IRQ_ON     = 16'hE001;	// Enable

	// SRAM sits in the 4 KB window at 7000h, decoded on A15..A12
	localparam logic [CPU_AW-1:0] SRAM_WINDOW = 16'h7000;

endpackage
